/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_snd
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Result: PASSED

SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* pcm_out.sv */
//====================================================================
// PCM output stage
// One pair per PCM enable, last pair repeated and counted on underrun
//====================================================================
`default_nettype none

module pcm_out (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              pcm_cen,             // Output sample slot
    input  wire              halt,                // Stops output so the FIFO fills
    snd_stream_if.receiver   in_s,                // Pairs from the FIFO
    output logic             pcm_stb,             // One cycle after each served slot
    output snd_pkg::sample_t pcm_left,
    output snd_pkg::sample_t pcm_right,
    output snd_pkg::cnt_t    underruns            // Slots served with a repeat
);

    import snd_pkg::*;

    logic take;                                   // Slot open to the FIFO

    assign take      = pcm_cen & ~halt;
    assign in_s.hold = ~take;                     // Link opens only in a served slot

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_stb   <= 1'b0;
            pcm_left  <= '0;
            pcm_right <= '0;
            underruns <= '0;
        end else begin
            pcm_stb <= take;                      // Stays low while halted
            if (in_s.stb) begin
                pcm_left  <= in_s.left;           // Fresh pair from the FIFO
                pcm_right <= in_s.right;
            end else if (take && underruns != CNT_MAX) begin
                underruns <= underruns + 1'b1;    // Output keeps the last pair
            end
        end
    end

endmodule

`default_nettype wire

/* sample_fifo.sv */
//====================================================================
// Stereo sample FIFO
// Holds the producer off when full and streams pairs to the output stage
//====================================================================
`default_nettype none

module sample_fifo (
    input  wire            clk,
    input  wire            rst_n,
    snd_stream_if.receiver in_s,                  // Pairs from the producer
    snd_stream_if.sender   out_s                  // Pairs to the output stage
);

    import snd_pkg::*;

    sample_t mem_l [FIFO_DEPTH];                  // Left sample storage
    sample_t mem_r [FIFO_DEPTH];                  // Right sample storage
    ptr_t    wr_ptr;                              // Next slot to write
    ptr_t    rd_ptr;                              // Head pair slot
    level_t  level;                               // Pairs stored
    logic    full;
    logic    empty;
    logic    push;                                // Pair accepted this cycle
    logic    pop;                                 // Head pair leaves this cycle

    // Step a pointer around the circular buffer
    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == PTR_LAST) ? '0 : ptr_t'(p + 1'b1);
    endfunction

    assign full  = (level == FIFO_FULL);
    assign empty = (level == '0);

    assign in_s.hold = full;                      // Producer drops its pair while full
    assign push      = in_s.stb & ~full;

    // Head is offered whenever something is stored and the consumer is open
    assign out_s.stb   = ~empty & ~out_s.hold;
    assign out_s.left  = mem_l[rd_ptr];
    assign out_s.right = mem_r[rd_ptr];
    assign pop         = out_s.stb;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_l[wr_ptr] <= in_s.left;           // Visible at the head one cycle later
            mem_r[wr_ptr] <= in_s.right;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;   // Write only
                2'b01:   level <= level - 1'b1;   // Read only
                default: level <= level;          // Both or neither keep the count
            endcase
        end
    end

endmodule

`default_nettype wire

/* snd_cen.sv */
//====================================================================
// Sound clock enable bank
// FM, double FM and PCM enables at fixed n/m ratios of the master clock
//====================================================================
`default_nettype none

module snd_cen (
    input  wire  clk,
    input  wire  rst_n,
    output logic fm_cen,                          // Every second double FM pulse
    output logic fm2_cen,                         // Double FM rate enable
    output logic pcm_cen                          // PCM sample rate enable
);

    import snd_pkg::*;

    acc_t fm_acc;                                 // Double FM accumulator state
    acc_t pcm_acc;                                // PCM accumulator state
    acc_t fm_sum;                                 // State plus FM_N
    acc_t pcm_sum;                                // State plus PCM_N
    logic fm_half;                                // High on the double FM pulse that is also FM

    // A pulse is due once the running sum reaches m
    function automatic logic frac_due(acc_t sum, acc_t m);
        return sum >= m;
    endfunction

    // Next accumulator state with m taken out on a pulse
    function automatic acc_t frac_wrap(acc_t sum, acc_t m);
        return (sum >= m) ? acc_t'(sum - m) : sum;
    endfunction

    assign fm_sum  = fm_acc + FM_N;               // Stays below FM_M plus FM_N
    assign pcm_sum = pcm_acc + PCM_N;

    assign fm2_cen = frac_due(fm_sum, FM_M);      // Combinational in the cycle it is due
    assign fm_cen  = fm2_cen & fm_half;           // Halves the double FM rate
    assign pcm_cen = frac_due(pcm_sum, PCM_M);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_acc  <= '0;                        // Gives exactly n pulses per m cycles
            pcm_acc <= '0;
            fm_half <= 1'b0;                      // First double FM pulse is not an FM pulse
        end else begin
            fm_acc  <= frac_wrap(fm_sum, FM_M);
            pcm_acc <= frac_wrap(pcm_sum, PCM_M);
            if (fm2_cen) begin
                fm_half <= ~fm_half;              // Alternates with each double FM pulse
            end
        end
    end

endmodule

`default_nettype wire

/* snd_pkg.sv */
//====================================================================
// Sound subsystem package
// Sample widths, clock enable ratios and sample FIFO sizing
//====================================================================
`default_nettype none

package snd_pkg;

    localparam int SAMPLE_W = 12;                 // Bits per audio sample
    localparam int VOL_W    = 4;                  // Volume scale, 0 to 15
    localparam int FREQ_W   = 16;                 // Phase accumulator width
    localparam int CNT_W    = 16;                 // Event counter width
    localparam int ACC_W    = 11;                 // Holds any m plus n below 2048

    typedef logic signed [SAMPLE_W-1:0] sample_t; // Signed audio sample
    typedef logic [FREQ_W-1:0]          freq_t;   // Phase step per double FM enable
    typedef logic [VOL_W-1:0]           vol_t;    // Output volume
    typedef logic [CNT_W-1:0]           cnt_t;    // Overflow and underrun counts
    typedef logic [ACC_W-1:0]           acc_t;    // Fractional enable accumulator

    // Double FM enable runs at 126/793 of the master clock
    localparam acc_t FM_N  = acc_t'(126);
    localparam acc_t FM_M  = acc_t'(793);
    localparam acc_t PCM_N = acc_t'(120);         // PCM enable at 120/1007
    localparam acc_t PCM_M = acc_t'(1007);

    localparam sample_t PEAK    = sample_t'(2047); // Square wave amplitude at full volume
    localparam cnt_t    CNT_MAX = '1;             // Counters stop here

    localparam int FIFO_DEPTH = 8;                // Stereo pairs in the buffer
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    typedef logic [FIFO_AW-1:0] ptr_t;            // Read and write slot index
    typedef logic [FIFO_AW:0]   level_t;          // Occupancy from 0 to FIFO_DEPTH

    localparam ptr_t   PTR_LAST  = ptr_t'(FIFO_DEPTH - 1);  // Pointers wrap after this slot
    localparam level_t FIFO_FULL = level_t'(FIFO_DEPTH);

endpackage

`default_nettype wire

/* snd_stream_if.sv */
//====================================================================
// Stereo sample link
// One pair moves in the cycle where stb is high and hold is low
//====================================================================
`default_nettype none

interface snd_stream_if;

    import snd_pkg::*;

    logic    stb;                                 // One cycle pair strobe from the sender
    sample_t left;                                // Left sample valid with stb
    sample_t right;                               // Right sample valid with stb
    logic    hold;                                // Receiver level that blocks the strobe

    // The sender keeps stb low while hold is high
    modport sender (
        output stb,
        output left,
        output right,
        input  hold
    );

    modport receiver (
        input  stb,
        input  left,
        input  right,
        output hold
    );

endinterface

`default_nettype wire

/* snd_testdata.txt */
# index freq(hex) vol run halt_cycles run_cycles pcm_stb_count left_sum_of_new_pairs
# index 1 rate, 2 samples, 3 underrun, 4 back-pressure, 5 volume zero; count -1 means per-cycle only
1 4000 15 1    0 10070 1200 -768000
2 0800  9 1    0  5035  600  -28800
3 0800 15 0    0  2014  240       0
4 0800 15 1 2014  3021   -1    4800
5 0800  0 1    0  3021  360       0

/* snd_top.sv */
//====================================================================
// Sound subsystem top level
// Enable bank, tone producer, sample FIFO and PCM output stage
//====================================================================
`default_nettype none

module snd_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 run,              // Producer emits pairs
    input  wire snd_pkg::freq_t freq,             // Tone phase step
    input  wire snd_pkg::vol_t  vol,              // Tone volume
    input  wire                 halt,             // Pauses the output stage
    output logic                pcm_stb,
    output snd_pkg::sample_t    pcm_left,
    output snd_pkg::sample_t    pcm_right,
    output snd_pkg::cnt_t       overflows,
    output snd_pkg::cnt_t       underruns
);

    logic fm_cen;
    logic fm2_cen;
    logic pcm_cen;

    snd_stream_if gen_link ();                    // Producer to FIFO
    snd_stream_if out_link ();                    // FIFO to output stage

    snd_cen u_cen (
        .clk     (clk),
        .rst_n   (rst_n),
        .fm_cen  (fm_cen),
        .fm2_cen (fm2_cen),
        .pcm_cen (pcm_cen)
    );

    tone_gen u_tone (
        .clk       (clk),
        .rst_n     (rst_n),
        .fm_cen    (fm_cen),
        .fm2_cen   (fm2_cen),
        .run       (run),
        .freq      (freq),
        .vol       (vol),
        .overflows (overflows),
        .out_s     (gen_link.sender)
    );

    sample_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (gen_link.receiver),
        .out_s (out_link.sender)
    );

    pcm_out u_pcm (
        .clk       (clk),
        .rst_n     (rst_n),
        .pcm_cen   (pcm_cen),
        .halt      (halt),
        .in_s      (out_link.receiver),
        .pcm_stb   (pcm_stb),
        .pcm_left  (pcm_left),
        .pcm_right (pcm_right),
        .underruns (underruns)
    );

endmodule

`default_nettype wire

/* tb_snd.sv */
//======================================================================
// Sound subsystem testbench
// Runs the tests of the data file and checks PCM rate, samples and counts
//======================================================================
`default_nettype none

module tb_snd;

    import snd_pkg::*;

    localparam int MAX_TESTS    = 16;
    localparam int BACKPRESSURE = 4;              // Test index with random halt toggles
    localparam int TIME_MARGIN  = 1000;           // Spare cycles on top of the test lengths

    logic    clk;
    logic    rst_n;
    logic    run;
    freq_t   freq;
    vol_t    vol;
    logic    halt;
    logic    pcm_stb;
    sample_t pcm_left;
    sample_t pcm_right;
    cnt_t    overflows;
    cnt_t    underruns;

    int t_idx    [MAX_TESTS];                     // Test name index
    int t_freq   [MAX_TESTS];
    int t_vol    [MAX_TESTS];
    int t_run    [MAX_TESTS];
    int t_halt   [MAX_TESTS];                     // Cycles held in halt after reset
    int t_cycles [MAX_TESTS];                     // Cycles run after the halt phase
    int t_count  [MAX_TESTS];                     // Expected pcm_stb count, -1 for none
    int t_sum    [MAX_TESTS];                     // Expected sum of new left samples

    int          num_tests   = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    string       test_name   = "setup";
    logic [31:0] lcg_state   = 32'h5755;

    snd_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .freq      (freq),
        .vol       (vol),
        .halt      (halt),
        .pcm_stb   (pcm_stb),
        .pcm_left  (pcm_left),
        .pcm_right (pcm_right),
        .overflows (overflows),
        .underruns (underruns)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic string name_of(int idx);
        case (idx)
            1:       return "rate";
            2:       return "samples";
            3:       return "underrun";
            4:       return "backpressure";
            5:       return "volume_zero";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Pair j comes from phase 2*j*freq, the top 12 bits scaled by vol over 16
    function automatic int saw_sample(int j, int f, int v);
        int ph;
        int top;
        ph  = (2 * j * f) % 65536;
        top = ph / 16;
        if (top >= 2048) begin
            top = top - 4096;                     // Signed reading of the top bits
        end
        return (top * v) >>> 4;
    endfunction

    function automatic int square_sample(int j, int f, int v);
        int ph;
        ph = (2 * j * f) % 65536;
        return ((ph >= 32768) ? -2047 * v : 2047 * v) >>> 4;
    endfunction

    task automatic check_value(string what, int expected, int actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic pick_gap(output int gap);
        lcg_state = lcg_next(lcg_state);
        gap       = 64 + int'(lcg_state[25:16]);  // 64 to 1087 cycles between toggles
    endtask

    task automatic load_tests();
        int    fd;
        int    got;
        string line;
        int    v [8];
        fd = $fopen("snd_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file snd_testdata.txt");
            $display("Result: FAILED");
            $fatal(1, "missing data file");
        end
        cycle_limit = TIME_MARGIN;
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line[0] != "#") begin
                got = $sscanf(line, "%d %h %d %d %d %d %d %d",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (got != 8 || num_tests >= MAX_TESTS) begin
                    $display("A line of the test data file could not be used: %s", line);
                    $display("Result: FAILED");
                    $fatal(1, "bad data file");
                end
                t_idx[num_tests]    = v[0];
                t_freq[num_tests]   = v[1];
                t_vol[num_tests]    = v[2];
                t_run[num_tests]    = v[3];
                t_halt[num_tests]   = v[4];
                t_cycles[num_tests] = v[5];
                t_count[num_tests]  = v[6];
                t_sum[num_tests]    = v[7];
                cycle_limit = cycle_limit + v[4] + v[5] + 4;  // Reset and one extra read
                num_tests   = num_tests + 1;
            end
        end
        $fclose(fd);
    endtask

    // Reset is asserted on a rising edge and released two edges later
    task automatic start_test(logic run_v, freq_t freq_v, vol_t vol_v, logic halt_v);
        @(posedge clk);
        rst_n <= 1'b0;
        run   <= run_v;
        freq  <= freq_v;
        vol   <= vol_v;
        halt  <= halt_v;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_test(int i);
        int   acc;                                // PCM enable accumulator model
        int   next_j;                             // Index of the last new pair seen
        int   budget;                             // New pairs whose values are checked
        int   checked;
        int   stb_count;
        int   left_sum;
        int   next_toggle;
        int   gap;
        int   last_left;
        int   last_right;
        int   last_under;
        logic prev_take;                          // Output slot served in the last cycle
        logic halt_cur;
        logic halt_next;
        logic cen;
        test_name   = name_of(t_idx[i]);
        acc         = 0;
        next_j      = 0;
        checked     = 0;
        stb_count   = 0;
        left_sum    = 0;
        last_left   = 0;
        last_right  = 0;
        last_under  = 0;
        prev_take   = 1'b0;
        halt_cur    = (t_halt[i] != 0);
        budget      = (t_idx[i] == BACKPRESSURE) ? FIFO_DEPTH : t_halt[i] + t_cycles[i] + 1;
        pick_gap(gap);
        next_toggle = t_halt[i] + gap;
        start_test(t_run[i] != 0, freq_t'(t_freq[i]), vol_t'(t_vol[i]), halt_cur);
        for (int cyc = 0; cyc <= t_halt[i] + t_cycles[i]; cyc++) begin
            @(posedge clk);
            check_value("pcm_stb", int'(prev_take), int'(pcm_stb));
            if (pcm_stb) begin
                stb_count = stb_count + 1;
                if (t_vol[i] == 0) begin
                    check_value("silent left", 0, int'(pcm_left));
                    check_value("silent right", 0, int'(pcm_right));
                end
                if (checked < budget) begin
                    if (int'(underruns) == last_under + 1) begin
                        check_value("repeated left", last_left, int'(pcm_left));
                        check_value("repeated right", last_right, int'(pcm_right));
                    end else begin
                        check_value("underruns", last_under, int'(underruns));
                        next_j = next_j + 1;
                        check_value("left", saw_sample(next_j, t_freq[i], t_vol[i]),
                                    int'(pcm_left));
                        check_value("right", square_sample(next_j, t_freq[i], t_vol[i]),
                                    int'(pcm_right));
                        left_sum = left_sum + int'(pcm_left);
                        checked  = checked + 1;
                    end
                end
                last_left  = int'(pcm_left);
                last_right = int'(pcm_right);
                last_under = int'(underruns);
            end
            cen = (acc + int'(PCM_N) >= int'(PCM_M));  // n added per cycle, m taken per pulse
            acc = cen ? acc + int'(PCM_N) - int'(PCM_M) : acc + int'(PCM_N);
            prev_take = cen & ~halt_cur;
            halt_next = halt_cur;
            if (cyc + 1 == t_halt[i]) begin
                halt_next = 1'b0;                 // End of the initial halt phase
            end else if (t_idx[i] == BACKPRESSURE && cyc + 1 == next_toggle) begin
                halt_next = ~halt_cur;
                pick_gap(gap);
                next_toggle = cyc + 1 + gap;
            end
            halt     <= halt_next;
            halt_cur  = halt_next;
        end
        if (t_count[i] >= 0) begin
            check_value("pcm_stb count", t_count[i], stb_count);
        end
        check_value("left sum", t_sum[i], left_sum);
        if (t_run[i] == 0) begin
            check_value("underrun count", stb_count, int'(underruns));
            check_value("overflows", 0, int'(overflows));
        end else if (t_halt[i] > 0) begin
            check_value("overflow seen", 1, int'(overflows != '0));
        end else begin
            check_value("overflows", 0, int'(overflows));
        end
        $display("Test %s: %0d strobes, %0d underruns, %0d overflows",
                 test_name, stb_count, underruns, overflows);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        run   = 1'b0;
        freq  = '0;
        vol   = '0;
        halt  = 1'b0;
        load_tests();
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        if (num_tests == 0) begin
            $display("The test data file holds no tests");
            $display("Result: FAILED");
            $fatal(1, "empty test list");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tone_gen.sv */
//====================================================================
// Tone producer
// Sawtooth left and square right from a phase accumulator at FM rate
//====================================================================
`default_nettype none

module tone_gen (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 fm_cen,           // Pair slot, always with fm2_cen
    input  wire                 fm2_cen,          // Phase step
    input  wire                 run,              // Emits pairs while high
    input  wire snd_pkg::freq_t freq,             // Phase step size
    input  wire snd_pkg::vol_t  vol,              // Output volume
    output snd_pkg::cnt_t       overflows,        // Pairs dropped on a full FIFO
    snd_stream_if.sender        out_s             // Pairs towards the FIFO
);

    import snd_pkg::*;

    localparam int MIX_W = SAMPLE_W + VOL_W + 1;  // Signed sample times signed volume

    freq_t                   phase;               // Current phase
    freq_t                   phase_nxt;           // Phase after this double FM step
    logic                    emit;                // Pair slot with the tone running
    logic                    drop;                // Pair slot blocked by the FIFO
    logic signed [VOL_W:0]   gain;                // Volume with a zero sign bit
    sample_t                 saw_level;           // Top phase bits read as signed
    sample_t                 sq_level;            // Plus or minus the peak
    logic signed [MIX_W-1:0] saw_prod;            // Scaled sawtooth before the shift
    logic signed [MIX_W-1:0] sq_prod;             // Scaled square before the shift

    assign phase_nxt = phase + freq;              // Wraps modulo 2**FREQ_W
    assign emit      = fm_cen & run;
    assign drop      = emit & out_s.hold;

    assign gain      = $signed({1'b0, vol});
    assign saw_level = phase_nxt[FREQ_W-1 -: SAMPLE_W];

    // Square is high for the first half of each period
    assign sq_level  = phase_nxt[FREQ_W-1] ? -PEAK : PEAK;

    assign saw_prod  = saw_level * gain;          // At most 15 times the sample range
    assign sq_prod   = sq_level * gain;

    // Pair is computed from the phase this FM step is writing
    assign out_s.stb   = emit & ~out_s.hold;     // Never strobes into a held link
    assign out_s.left  = sample_t'(saw_prod >>> VOL_W);
    assign out_s.right = sample_t'(sq_prod >>> VOL_W);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (fm2_cen) begin
            phase <= phase_nxt;                   // Advances with or without run
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflows <= '0;
        end else if (drop && overflows != CNT_MAX) begin
            overflows <= overflows + 1'b1;        // Saturates at CNT_MAX
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
snd_pkg.sv
snd_stream_if.sv
snd_cen.sv
tone_gen.sv
sample_fifo.sv
pcm_out.sv
snd_top.sv
tb_snd.sv
